// ==== source/memSubsystem_config.svh ====
`ifndef MEM_SUBSYSTEM_CONFIG_SVH
`define MEM_SUBSYSTEM_CONFIG_SVH

// byte address into main memory
`define ADDR_WIDTH 17

// one byte per location, 128 KiB
`define RAM_DEPTH 131072

// first fetch address after reset
`define RESET_PC 17'h00000

// instruction and data word
`define WORD_WIDTH 32

`endif

// ==== source/memPkg.sv ====
`default_nettype none

package memPkg;

    // RV32 load/store opcodes as seen by the data port
    typedef enum logic [2:0] {
        LB,
        LH,
        LW,
        LBU,
        LHU,
        SB,
        SH,
        SW
    } memOp;

    // transfer the byte sequencer is working on
    typedef enum logic [1:0] {
        IDLE,
        LOAD,
        STORE,
        FETCH
    } xferKind;

endpackage

`default_nettype wire

// ==== source/byteRam.sv ====
`default_nettype none
`include "memSubsystem_config.svh"

module byteRam (
    input  wire                    clk,
    input  wire [`ADDR_WIDTH-1:0] ramAddr,
    input  wire                    ramWe,
    input  wire [7:0]              ramDin,
    output logic [7:0]             ramDout
);

    logic [7:0] mem [`RAM_DEPTH];

    // write at the edge, read data one cycle after the address
    always_ff @(posedge clk) begin
        if (ramWe) begin
            mem[ramAddr] <= ramDin;
        end
        ramDout <= mem[ramAddr];
    end

endmodule

`default_nettype wire

// ==== source/memCtrl.sv ====
`default_nettype none
`include "memSubsystem_config.svh"

module memCtrl (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    rdy,

    // instruction fetch client
    input  wire                    fetchReq,
    input  wire [`ADDR_WIDTH-1:0] fetchAddr,
    output logic                   fetchDone,
    output logic [`WORD_WIDTH-1:0] fetchWord,

    // data client
    input  wire                    dataReq,
    input  wire                    dataWrite,
    input  wire [2:0]              dataLen,
    input  wire [`ADDR_WIDTH-1:0] dataAddr,
    input  wire [`WORD_WIDTH-1:0] dataWdata,
    output logic                   dataDone,
    output logic [`WORD_WIDTH-1:0] dataRdata,

    // byte RAM port
    output logic [`ADDR_WIDTH-1:0] ramAddr,
    output logic                   ramWe,
    output logic [7:0]             ramDin,
    input  wire [7:0]              ramDout
);

    memPkg::xferKind kind;
    logic [2:0] cnt;

    logic [`WORD_WIDTH-1:0] asmWord;
    logic [`ADDR_WIDTH-1:0] lastAddr;

    logic selData;
    logic selFetch;
    logic isStore;
    logic [2:0] idx;
    logic [1:0] idxLane;
    logic [1:0] lane;
    logic [`ADDR_WIDTH-1:0] base;
    logic [`ADDR_WIDTH-1:0] curAddr;
    logic [`WORD_WIDTH-1:0] readWord;
    logic storeLast;
    logic loadLast;
    logic fetchLast;

    // client choice is made only at idle, data first
    assign selData = (kind == memPkg::IDLE) ? dataReq
                   : (kind == memPkg::LOAD || kind == memPkg::STORE);
    assign selFetch = (kind == memPkg::IDLE) ? (!dataReq && fetchReq)
                    : (kind == memPkg::FETCH);
    assign isStore = selData && dataWrite;

    // byte index of the access issued this cycle
    assign idx = (kind == memPkg::IDLE) ? 3'd0 : cnt;
    assign idxLane = idx[1:0];

    assign base = selData ? dataAddr : fetchAddr;
    assign curAddr = base + `ADDR_WIDTH'(idx);

    // the stretch of cycles where rdy is low re-reads the last byte,
    // so ramDout still carries it when the sequence resumes
    assign ramAddr = rdy ? curAddr : lastAddr;
    assign ramWe = rdy && isStore;
    assign ramDin = dataWdata[8*idxLane +: 8];

    // lane of the byte now on ramDout, one behind the address
    assign lane = cnt[1:0] - 2'd1;
    assign readWord = asmWord | ({{(`WORD_WIDTH-8){1'b0}}, ramDout} << (8 * lane));

    // store finishes with its last write, loads one cycle after their last address
    assign storeLast = isStore && ((idx + 3'd1) == dataLen);
    assign loadLast = (kind == memPkg::LOAD) && (cnt == dataLen);
    assign fetchLast = (kind == memPkg::FETCH) && (cnt == 3'd4);

    assign dataDone = rdy && (storeLast || loadLast);
    assign fetchDone = rdy && fetchLast;

    assign dataRdata = readWord;
    assign fetchWord = readWord;

    always_ff @(posedge clk) begin
        if (rst) begin
            kind <= memPkg::IDLE;
            cnt <= 3'd0;
        end else if (rdy) begin
            if (dataDone || fetchDone) begin
                kind <= memPkg::IDLE;
                cnt <= 3'd0;
            end else if (kind == memPkg::IDLE) begin
                if (selData) begin
                    kind <= dataWrite ? memPkg::STORE : memPkg::LOAD;
                    cnt <= 3'd1;
                end else if (selFetch) begin
                    kind <= memPkg::FETCH;
                    cnt <= 3'd1;
                end
            end else begin
                cnt <= cnt + 3'd1;
            end
        end
    end

    // assembly word and re-read address
    always_ff @(posedge clk) begin
        if (rdy) begin
            lastAddr <= curAddr;
            if (kind == memPkg::IDLE) begin
                asmWord <= '0;
            end else begin
                asmWord[8*lane +: 8] <= ramDout;
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/fetchUnit.sv ====
`default_nettype none
`include "memSubsystem_config.svh"

module fetchUnit (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    rdy,
    input  wire                    fetchEn,
    input  wire                    redirect,
    input  wire [`ADDR_WIDTH-1:0] redirectPc,

    // to the byte sequencer
    output logic                   fetchReq,
    output logic [`ADDR_WIDTH-1:0] fetchAddr,
    input  wire                    fetchDone,
    input  wire [`WORD_WIDTH-1:0] fetchWord,

    // instruction stream
    output logic                   instValid,
    output logic [`WORD_WIDTH-1:0] inst,
    output logic [`ADDR_WIDTH-1:0] instPc
);

    localparam logic [`ADDR_WIDTH-1:0] pcStep = `ADDR_WIDTH'(4);

    logic [`ADDR_WIDTH-1:0] pc;
    logic stale;

    // a word fetched before a redirect never reaches the stream
    assign instValid = fetchDone && !stale && !redirect;
    assign inst = fetchWord;
    assign instPc = fetchAddr;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= `RESET_PC;
            fetchReq <= 1'b0;
            stale <= 1'b0;
        end else if (rdy) begin
            if (redirect) begin
                pc <= redirectPc;
            end else if (instValid) begin
                pc <= fetchAddr + pcStep;
            end

            if (fetchReq) begin
                if (fetchDone) begin
                    fetchReq <= 1'b0;
                    stale <= 1'b0;
                end else if (redirect) begin
                    stale <= 1'b1;
                end
            end else if (fetchEn) begin
                fetchReq <= 1'b1;
                fetchAddr <= redirect ? redirectPc : pc;
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/dataPort.sv ====
`default_nettype none
`include "memSubsystem_config.svh"

module dataPort (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    rdy,

    // load/store request from the core
    input  wire                    reqValid,
    input  var memPkg::memOp       op,
    input  wire [`ADDR_WIDTH-1:0] addr,
    input  wire [`WORD_WIDTH-1:0] storeData,
    output logic                   dataBusy,
    output logic                   loadDone,
    output logic [`WORD_WIDTH-1:0] loadData,

    // to the byte sequencer
    output logic                   dataReq,
    output logic                   dataWrite,
    output logic [2:0]             dataLen,
    output logic [`ADDR_WIDTH-1:0] dataAddr,
    output logic [`WORD_WIDTH-1:0] dataWdata,
    input  wire                    dataDone,
    input  wire [`WORD_WIDTH-1:0] dataRdata
);

    memPkg::memOp opReg;

    assign dataBusy = dataReq;
    assign loadDone = dataDone;

    // write flag and byte count from the latched opcode
    always_comb begin
        case (opReg)
            memPkg::SB: begin
                dataWrite = 1'b1;
                dataLen = 3'd1;
            end
            memPkg::SH: begin
                dataWrite = 1'b1;
                dataLen = 3'd2;
            end
            memPkg::SW: begin
                dataWrite = 1'b1;
                dataLen = 3'd4;
            end
            memPkg::LH, memPkg::LHU: begin
                dataWrite = 1'b0;
                dataLen = 3'd2;
            end
            memPkg::LW: begin
                dataWrite = 1'b0;
                dataLen = 3'd4;
            end
            default: begin
                dataWrite = 1'b0;
                dataLen = 3'd1;
            end
        endcase
    end

    // raw bytes arrive zero-extended
    always_comb begin
        case (opReg)
            memPkg::LB:  loadData = {{24{dataRdata[7]}}, dataRdata[7:0]};
            memPkg::LH:  loadData = {{16{dataRdata[15]}}, dataRdata[15:0]};
            memPkg::LW, memPkg::LBU, memPkg::LHU: loadData = dataRdata;
            default:     loadData = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            dataReq <= 1'b0;
        end else if (rdy) begin
            if (reqValid) begin
                dataReq <= 1'b1;
            end else if (dataDone) begin
                dataReq <= 1'b0;
            end
        end
    end

    // operands stay put until the sequencer is done
    always_ff @(posedge clk) begin
        if (rdy && reqValid) begin
            opReg <= op;
            dataAddr <= addr;
            dataWdata <= storeData;
        end
    end

endmodule

`default_nettype wire

// ==== source/memSubsystem.sv ====
`default_nettype none
`include "memSubsystem_config.svh"

module memSubsystem (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    rdy,

    // instruction side
    input  wire                    fetchEn,
    input  wire                    redirect,
    input  wire [`ADDR_WIDTH-1:0] redirectPc,
    output wire                    instValid,
    output wire [`WORD_WIDTH-1:0] inst,
    output wire [`ADDR_WIDTH-1:0] instPc,

    // load/store side
    input  wire                    reqValid,
    input  var memPkg::memOp       op,
    input  wire [`ADDR_WIDTH-1:0] addr,
    input  wire [`WORD_WIDTH-1:0] storeData,
    output wire                    dataBusy,
    output wire                    loadDone,
    output wire [`WORD_WIDTH-1:0] loadData
);

    wire                    fetchReq;
    wire [`ADDR_WIDTH-1:0] fetchAddr;
    wire                    fetchDone;
    wire [`WORD_WIDTH-1:0] fetchWord;

    wire                    dataReq;
    wire                    dataWrite;
    wire [2:0]              dataLen;
    wire [`ADDR_WIDTH-1:0] dataAddr;
    wire [`WORD_WIDTH-1:0] dataWdata;
    wire                    dataDone;
    wire [`WORD_WIDTH-1:0] dataRdata;

    wire [`ADDR_WIDTH-1:0] ramAddr;
    wire                    ramWe;
    wire [7:0]              ramDin;
    wire [7:0]              ramDout;

    fetchUnit fetch (
        .clk(clk),
        .rst(rst),
        .rdy(rdy),
        .fetchEn(fetchEn),
        .redirect(redirect),
        .redirectPc(redirectPc),
        .fetchReq(fetchReq),
        .fetchAddr(fetchAddr),
        .fetchDone(fetchDone),
        .fetchWord(fetchWord),
        .instValid(instValid),
        .inst(inst),
        .instPc(instPc)
    );

    dataPort data (
        .clk(clk),
        .rst(rst),
        .rdy(rdy),
        .reqValid(reqValid),
        .op(op),
        .addr(addr),
        .storeData(storeData),
        .dataBusy(dataBusy),
        .loadDone(loadDone),
        .loadData(loadData),
        .dataReq(dataReq),
        .dataWrite(dataWrite),
        .dataLen(dataLen),
        .dataAddr(dataAddr),
        .dataWdata(dataWdata),
        .dataDone(dataDone),
        .dataRdata(dataRdata)
    );

    memCtrl ctrl (
        .clk(clk),
        .rst(rst),
        .rdy(rdy),
        .fetchReq(fetchReq),
        .fetchAddr(fetchAddr),
        .fetchDone(fetchDone),
        .fetchWord(fetchWord),
        .dataReq(dataReq),
        .dataWrite(dataWrite),
        .dataLen(dataLen),
        .dataAddr(dataAddr),
        .dataWdata(dataWdata),
        .dataDone(dataDone),
        .dataRdata(dataRdata),
        .ramAddr(ramAddr),
        .ramWe(ramWe),
        .ramDin(ramDin),
        .ramDout(ramDout)
    );

    byteRam ram (
        .clk(clk),
        .ramAddr(ramAddr),
        .ramWe(ramWe),
        .ramDin(ramDin),
        .ramDout(ramDout)
    );

endmodule

`default_nettype wire

// ==== testbench/memSubsystem_checker.sv ====
`default_nettype none

module memSubsystem_checker (
    input wire            clk,
    input wire            rst,
    input var memPkg::xferKind kind,
    input wire            ramWe,
    input wire            dataDone,
    input wire            fetchDone,
    input wire            reqValid,
    input wire            dataBusy
);

    // a store writes its first byte while still idle
    writeKindOk: assert property (@(posedge clk) disable iff (rst)
        ramWe |-> (kind != memPkg::LOAD && kind != memPkg::FETCH))
        else $error("RAM write during a load or fetch");

    noReqWhileBusy: assert property (@(posedge clk) disable iff (rst)
        reqValid |-> !dataBusy)
        else $error("new request while the data port is busy");

    dataDonePulse: assert property (@(posedge clk) disable iff (rst)
        dataDone |=> !dataDone)
        else $error("dataDone longer than one cycle");

    fetchDonePulse: assert property (@(posedge clk) disable iff (rst)
        fetchDone |=> !fetchDone)
        else $error("fetchDone longer than one cycle");

endmodule

bind memSubsystem memSubsystem_checker chk (
    .clk(clk),
    .rst(rst),
    .kind(ctrl.kind),
    .ramWe(ctrl.ramWe),
    .dataDone(ctrl.dataDone),
    .fetchDone(ctrl.fetchDone),
    .reqValid(reqValid),
    .dataBusy(dataBusy)
);

`default_nettype wire

// ==== testbench/memSubsystem_tb.sv ====
`default_nettype none
`include "memSubsystem_config.svh"

module memSubsystem_tb;

    localparam int numOps = 400;
    localparam logic [`ADDR_WIDTH-1:0] dataBase = `ADDR_WIDTH'('h10000);

    logic clk = 1'b0;
    logic rst, rdy, fetchEn, redirect, reqValid;
    logic [`ADDR_WIDTH-1:0] redirectPc, addr;
    logic [`WORD_WIDTH-1:0] storeData;
    memPkg::memOp op;
    wire instValid, dataBusy, loadDone;
    wire [`WORD_WIDTH-1:0] inst, loadData;
    wire [`ADDR_WIDTH-1:0] instPc;

    logic [7:0] model [`RAM_DEPTH];
    integer seed = 75;
    memPkg::memOp pendOp;
    logic [`ADDR_WIDTH-1:0] pendAddr, expPc;
    logic stallOn;
    int instCount;

    memSubsystem uut (
        .clk(clk), .rst(rst), .rdy(rdy), .fetchEn(fetchEn), .redirect(redirect),
        .redirectPc(redirectPc), .instValid(instValid), .inst(inst), .instPc(instPc),
        .reqValid(reqValid), .op(op), .addr(addr), .storeData(storeData),
        .dataBusy(dataBusy), .loadDone(loadDone), .loadData(loadData)
    );

    always #10 clk = ~clk;

    function automatic logic isStoreOp(input memPkg::memOp o);
        return o == memPkg::SB || o == memPkg::SH || o == memPkg::SW;
    endfunction

    function automatic int lenOf(input memPkg::memOp o);
        case (o)
            memPkg::LW, memPkg::SW: return 4;
            memPkg::LH, memPkg::LHU, memPkg::SH: return 2;
            default: return 1;
        endcase
    endfunction

    // RV32 load semantics over the byte model, little endian
    function automatic logic [31:0] expectLoad(input memPkg::memOp o, input logic [16:0] a);
        logic [31:0] w;
        w = {model[a + 17'd3], model[a + 17'd2], model[a + 17'd1], model[a]};
        case (o)
            memPkg::LB:  return {{24{w[7]}}, w[7:0]};
            memPkg::LBU: return {24'd0, w[7:0]};
            memPkg::LH:  return {{16{w[15]}}, w[15:0]};
            memPkg::LHU: return {16'd0, w[15:0]};
            memPkg::LW:  return w;
            default:     return 32'd0;
        endcase
    endfunction

    task automatic checkEq(input logic [31:0] got, input logic [31:0] exp, input string msg);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, msg, got, exp);
            $display("Result: FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    // one data access, returns edges from the first reqValid edge to loadDone
    task automatic doOp(input memPkg::memOp o, input logic [16:0] a, input logic [31:0] d,
                        output int lat);
        lat = 0;
        @(negedge clk);
        op = o;
        addr = a;
        storeData = d;
        reqValid = 1'b1;
        pendOp = o;
        pendAddr = a;
        if (isStoreOp(o)) begin
            for (int i = 0; i < lenOf(o); i++) begin
                model[a + 17'(i)] = d[8*i +: 8];
            end
        end
        do begin
            @(posedge clk);
            checkEq(32'(dataBusy), 32'd0, "dataBusy before accept");
            lat++;
        end while (!rdy);
        @(negedge clk);
        reqValid = 1'b0;
        // busy from acceptance through the done pulse
        do begin
            @(posedge clk);
            checkEq(32'(dataBusy), 32'd1, "dataBusy");
            lat++;
        end while (!loadDone);
    endtask

    task automatic randomOps(input int count);
        int lat;
        memPkg::memOp o;
        for (int i = 0; i < count; i++) begin
            o = memPkg::memOp'($unsigned($random(seed)) % 8);
            doOp(o, dataBase + 17'($unsigned($random(seed)) % 60), $random(seed), lat);
        end
    endtask

    task automatic waitInst(input int n);
        int target;
        target = instCount + n;
        while (instCount < target) @(posedge clk);
    endtask

    // redirect a few cycles after an instruction, so a fetch is in flight
    task automatic jumpTo(input logic [16:0] target);
        while (!instValid) @(posedge clk);
        repeat (2) @(negedge clk);
        redirect = 1'b1;
        redirectPc = target;
        expPc = target;
        @(negedge clk);
        redirect = 1'b0;
    endtask

    always @(posedge clk) begin
        if (!rst) begin
            if (!rdy) begin
                checkEq(32'(loadDone), 32'd0, "loadDone while stalled");
                checkEq(32'(instValid), 32'd0, "instValid while stalled");
            end
            if (loadDone) begin
                checkEq(loadData, expectLoad(pendOp, pendAddr), "loadData");
            end
            if (instValid) begin
                checkEq(32'(instPc), 32'(expPc), "instPc");
                checkEq(inst, expectLoad(memPkg::LW, expPc), "inst");
                expPc = expPc + 17'd4;
                instCount++;
            end
        end
    end

    always @(negedge clk) begin
        if (stallOn) rdy = ($unsigned($random(seed)) % 3) != 0;
    end

    initial begin
        #(numOps * 20 * 20 + 20000);
        $display("timeout: the test did not finish in time");
        $display("Result: FAILED");
        $fatal(1, "watchdog expired");
    end

    initial begin
        int lat;
        rst = 1'b1;
        rdy = 1'b1;
        fetchEn = 1'b0;
        redirect = 1'b0;
        redirectPc = '0;
        reqValid = 1'b0;
        op = memPkg::LB;
        addr = '0;
        storeData = '0;
        stallOn = 1'b0;
        instCount = 0;
        expPc = `RESET_PC;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // code words low, data region high
        for (int i = 0; i < 256; i++) doOp(memPkg::SW, 17'(4 * i), $random(seed), lat);
        for (int i = 0; i < 16; i++) doOp(memPkg::SW, dataBase + 17'(4 * i), $random(seed), lat);
        randomOps(40);

        for (int i = 0; i < 8; i++) begin
            doOp(memPkg::memOp'(i), dataBase + 17'(8 * i + 1), $random(seed), lat);
            checkEq(lat, isStoreOp(memPkg::memOp'(i)) ? lenOf(memPkg::memOp'(i)) + 1
                                                      : lenOf(memPkg::memOp'(i)) + 2,
                    "idle latency");
        end

        fetchEn = 1'b1;
        waitInst(12);
        randomOps(30);
        waitInst(4);

        jumpTo(17'h40);
        waitInst(4);
        jumpTo(17'h10);
        waitInst(4);

        stallOn = 1'b1;
        randomOps(30);
        waitInst(8);
        stallOn = 1'b0;
        @(negedge clk);
        rdy = 1'b1;
        fetchEn = 1'b0;
        repeat (20) @(posedge clk);

        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+source
source/memPkg.sv
source/byteRam.sv
source/memCtrl.sv
source/fetchUnit.sv
source/dataPort.sv
source/memSubsystem.sv
testbench/memSubsystem_checker.sv
testbench/memSubsystem_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the memory subsystem testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
    -f project.f \
    --top-module memSubsystem_tb \
    -o simv

# the simulator exits non-zero on $fatal, the log decides the verdict
./obj_dir/simv > sim.log 2>&1 || true
cat sim.log

if grep -q "Result: FAILED" sim.log; then
    exit 1
fi
exit 0
